/* common/nes_cart_pkg.sv */
// Cartridge image definitions for the iNES loader
// Header layout, load addresses, mapper flags word and loader states

package nes_cart_pkg;

// iNES header layout
localparam int ines_hdr_bytes   = 16;
localparam logic [7:0] ines_magic0 = 8'h4E;	// 'N'
localparam logic [7:0] ines_magic1 = 8'h45;	// 'E'
localparam logic [7:0] ines_magic2 = 8'h53;	// 'S'
localparam logic [7:0] ines_magic3 = 8'h1A;	// EOF marker
localparam int ines_prg_pos     = 4;	// PRG page count, 16K each
localparam int ines_chr_pos     = 5;	// CHR page count, 8K each, zero means CHR RAM
localparam int ines_flags6_pos  = 6;
localparam int ines_flags7_pos  = 7;
localparam int ines_sub_pos     = 8;	// NES 2.0 mapper high bits and submapper
localparam int ines_tail_pos    = 9;	// First byte of the dirty-header check
localparam int ines_ram_pos     = 10;	// NES 2.0 PRG RAM shift
localparam int ines_trainer_bit = 2;

// Memory map
localparam int prg_page_shift = 14;
localparam int chr_page_shift = 13;
localparam int mem_addr_w     = 22;

typedef logic [mem_addr_w-1:0] mem_addr_t;

localparam mem_addr_t chr_base_addr = 22'h200000;

typedef struct packed {
	logic [1:0] pad;
	logic [3:0] prg_ram_shift;
	logic       has_saves;
	logic [7:0] submapper;
	logic       four_screen;
	logic       has_chr_ram;
	logic       mirroring;
	logic [2:0] chr_size;
	logic [2:0] prg_size;
	logic [7:0] mapper;
} mapper_flags_t;

typedef struct packed {
	logic      wr;
	mem_addr_t addr;
	logic [7:0] data;
} mem_wr_t;

typedef enum logic [2:0] {S_IDLE, S_HEADER, S_PRG, S_CHR, S_ERROR, S_DONE} load_state_e;

endpackage

/* common/nes_cheat_pkg.sv */
// Cheat code definitions
// A cheat download is a stream of fixed size codes, 16 bytes each

package nes_cheat_pkg;

// File type code of a cheat download
localparam logic [7:0] cheat_filetype = 8'hFF;

// Bytes per code, four 32-bit fields
localparam int cheat_bytes = 16;

/////////////////////////////////////////////////////////////////////
// Code layout, first received field at the top
//   flags   127:96
//   address  95:64
//   compare  63:32
//   replace  31:0
/////////////////////////////////////////////////////////////////////

typedef struct packed {
	logic [31:0] flags;
	logic [31:0] addr;
	logic [31:0] compare;
	logic [31:0] replace;
} cheat_code_t;

endpackage

/* loader/ines_header.sv */
// iNES header capture and decode
// Collects the 16 header bytes, checks signature and trainer bit,
// and builds the mapper flags word
`timescale 1ns/100ps

module ines_header
	import nes_cart_pkg::*;
(
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          restart,
	input  logic          hdr_wr,
	input  logic [7:0]    data,
	input  logic          invert_mirroring,
	output logic          hdr_done,
	output logic          hdr_ok,
	output logic [7:0]    prg_pages,
	output logic [7:0]    chr_pages,
	output mapper_flags_t mapper_flags
);

// Page count to log2 bucket, saturates at 7
function automatic logic [2:0] size_code(input logic [7:0] pages);
	logic [2:0] code;
	code = 3'd7;
	for (int i = 6; i >= 0; i--) begin
		if (pages <= 8'(1 << i))
			code = 3'(i);
	end
	return code;
endfunction

logic [7:0] hdr [ines_hdr_bytes];
logic [$clog2(ines_hdr_bytes)-1:0] cnt;
logic [$clog2(ines_hdr_bytes)-1:0] slot;
logic take;
logic sig_ok;
logic trainer;
logic is_nes20;
logic tail_nz;
logic is_dirty;

assign slot = restart ? '0 : cnt;	// A restart strobe lands in byte 0
assign take = hdr_wr && (restart || !hdr_done);

assign sig_ok = hdr[0] == ines_magic0 && hdr[1] == ines_magic1 &&
		hdr[2] == ines_magic2 && hdr[3] == ines_magic3;
assign trainer = hdr[ines_flags6_pos][ines_trainer_bit];

always_ff @(posedge clk) begin
	if (reset_nes) begin
		cnt      <= '0;
		hdr_done <= 1'b0;
		hdr_ok   <= 1'b0;
	end else if (restart) begin
		cnt      <= $bits(cnt)'(hdr_wr);
		hdr_done <= 1'b0;
		hdr_ok   <= 1'b0;
	end else if (take) begin
		cnt <= cnt + 1'b1;
		if (cnt == $bits(cnt)'(ines_hdr_bytes - 1)) begin
			hdr_done <= 1'b1;
			hdr_ok   <= sig_ok && !trainer;	// Bytes 0 to 6 are in by now
		end
	end
end

always_ff @(posedge clk) begin
	if (take)
		hdr[slot] <= data;
end

assign prg_pages = hdr[ines_prg_pos];
assign chr_pages = hdr[ines_chr_pos];

// NES 2.0 marker sits in byte 7 bits 3:2
assign is_nes20 = hdr[ines_flags7_pos][3:2] == 2'b10;

always_comb begin
	tail_nz = |hdr[ines_tail_pos][7:1];	// Bit 0 of byte 9 is allowed
	for (int i = ines_tail_pos + 1; i < ines_hdr_bytes; i++)
		tail_nz = tail_nz | (|hdr[i]);
end

assign is_dirty = !is_nes20 && tail_nz;	// Junk in padding, distrust byte 7

always_comb begin
	mapper_flags.pad           = 2'b00;
	mapper_flags.prg_ram_shift = is_nes20 ? hdr[ines_ram_pos][3:0] : 4'h0;
	mapper_flags.has_saves     = hdr[ines_flags6_pos][1];
	mapper_flags.submapper     = is_nes20 ? hdr[ines_sub_pos] : 8'h00;
	mapper_flags.four_screen   = hdr[ines_flags6_pos][3];
	mapper_flags.has_chr_ram   = chr_pages == 8'd0;
	mapper_flags.mirroring     = hdr[ines_flags6_pos][0] ^ invert_mirroring;
	mapper_flags.chr_size      = size_code(chr_pages);
	mapper_flags.prg_size      = size_code(prg_pages);
	mapper_flags.mapper        = {is_dirty ? 4'h0 : hdr[ines_flags7_pos][7:4],
		hdr[ines_flags6_pos][7:4]};
end

endmodule

/* loader/rom_load_fsm.sv */
// ROM load sequencer
// Steps through header, PRG and CHR phases, generates memory writes
// and reports busy, done and error
`timescale 1ns/100ps

module rom_load_fsm
	import nes_cart_pkg::*;
(
	input  logic       clk,
	input  logic       reset_nes,
	input  logic       rom_download,
	input  logic       rom_wr,
	input  logic [7:0] data,
	input  logic       hdr_done,
	input  logic       hdr_ok,
	input  logic [7:0] prg_pages,
	input  logic [7:0] chr_pages,
	output logic       hdr_wr,
	output logic       restart,
	output mem_wr_t    mem_wr,
	output logic       busy,
	output logic       done,
	output logic       error
);

load_state_e state;
logic        dl_q;	// Download level, one cycle late
mem_addr_t   bytes_left;
mem_addr_t   ptr;
logic        in_data;
logic        last_byte;

assign restart = rom_download && !dl_q;
assign hdr_wr  = rom_wr && (state == S_HEADER || restart);
assign in_data = state == S_PRG || state == S_CHR;

always_comb begin
	mem_wr.wr   = rom_wr && in_data && bytes_left != '0 && !restart;
	mem_wr.addr = ptr;
	mem_wr.data = data;
end

// Phase ends on an empty count or on its final write
assign last_byte = bytes_left == '0 || (mem_wr.wr && bytes_left == mem_addr_t'(1));

//////////////////////////////////////////////////////////////////////
// State register and counters
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (reset_nes)
		dl_q <= 1'b0;
	else
		dl_q <= rom_download;
end

always_ff @(posedge clk) begin
	if (reset_nes || restart) begin
		state      <= S_HEADER;
		busy       <= 1'b0;
		done       <= 1'b0;
		error      <= 1'b0;
		bytes_left <= '0;
		ptr        <= '0;
	end else begin
		case (state)
		S_HEADER: begin
			if (hdr_done) begin
				busy <= 1'b1;
				if (hdr_ok) begin
					state      <= S_PRG;
					ptr        <= '0;	// PRG from the bottom
					bytes_left <= mem_addr_t'(prg_pages) << prg_page_shift;
				end else begin
					state <= S_ERROR;
				end
			end
		end
		S_PRG, S_CHR: begin
			if (mem_wr.wr) begin
				bytes_left <= bytes_left - 1'b1;
				ptr        <= ptr + 1'b1;
			end
			if (last_byte) begin
				if (state == S_PRG) begin
					state      <= S_CHR;
					ptr        <= chr_base_addr;
					bytes_left <= mem_addr_t'(chr_pages) << chr_page_shift;
				end else begin
					state <= S_DONE;
				end
			end
		end
		S_ERROR: begin
			error <= 1'b1;
			done  <= 1'b1;
			busy  <= 1'b0;
		end
		S_DONE: begin
			done <= 1'b1;	// Flags valid from here
			busy <= 1'b0;
		end
		S_IDLE: begin
			// Parked until the next download
		end
		default: state <= S_IDLE;
		endcase
	end
end

endmodule

/* logic/cheat_code_assembler.sv */
// Cheat code assembler
// Packs each group of 16 cheat bytes into one code and flags it valid
`timescale 1ns/100ps

module cheat_code_assembler
	import nes_cheat_pkg::*;
(
	input  logic        clk,
	input  logic        reset_nes,
	input  logic        cheat_active,
	input  logic        cheat_wr,
	input  logic [7:0]  data,
	output cheat_code_t cheat_code,
	output logic        cheat_valid
);

logic [3:0] idx;	// Next byte within the code
logic       active_q;
logic [3:0] byte_sel;
logic [6:0] bit_pos;

// A new download starts over at byte 0
assign byte_sel = (cheat_active && !active_q) ? 4'd0 : idx;

// Field from the top, byte within field from the bottom
assign bit_pos = {~byte_sel[3:2], byte_sel[1:0], 3'b000};

always_ff @(posedge clk) begin
	if (reset_nes) begin
		idx         <= '0;
		active_q    <= 1'b0;
		cheat_valid <= 1'b0;
	end else begin
		active_q    <= cheat_active;
		cheat_valid <= 1'b0;
		if (cheat_wr) begin
			idx <= byte_sel + 1'b1;	// Wraps into the next code
			if (byte_sel == 4'(cheat_bytes - 1))
				cheat_valid <= 1'b1;
		end else if (cheat_active && !active_q) begin
			idx <= '0;
		end
	end
end

always_ff @(posedge clk) begin
	if (cheat_wr)
		cheat_code[bit_pos +: 8] <= data;
end

endmodule

/* logic/nes_loader.sv */
// Cartridge and cheat loader top level
// Sends a download either to the ROM loader or to the cheat assembler
`timescale 1ns/100ps

module nes_loader
	import nes_cart_pkg::*, nes_cheat_pkg::*;
(
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          download,
	input  logic [7:0]    filetype,
	input  logic [7:0]    data,
	input  logic          data_wr,
	input  logic          invert_mirroring,
	output mem_wr_t       mem_wr,
	output mapper_flags_t mapper_flags,
	output logic          busy,
	output logic          done,
	output logic          error,
	output cheat_code_t   cheat_code,
	output logic          cheat_valid
);

logic       is_cheat;
logic       rom_download;
logic       rom_wr;
logic       cheat_active;
logic       cheat_wr;
logic       hdr_wr;
logic       restart;
logic       hdr_done;
logic       hdr_ok;
logic [7:0] prg_pages;
logic [7:0] chr_pages;

// Download classification
assign is_cheat     = filetype == cheat_filetype;
assign rom_download = download && !is_cheat;
assign rom_wr       = data_wr && rom_download;
assign cheat_active = download && is_cheat;
assign cheat_wr     = data_wr && cheat_active;

rom_load_fsm u_fsm (
	.clk          (clk),
	.reset_nes    (reset_nes),
	.rom_download (rom_download),
	.rom_wr       (rom_wr),
	.data         (data),
	.hdr_done     (hdr_done),
	.hdr_ok       (hdr_ok),
	.prg_pages    (prg_pages),
	.chr_pages    (chr_pages),
	.hdr_wr       (hdr_wr),
	.restart      (restart),
	.mem_wr       (mem_wr),
	.busy         (busy),
	.done         (done),
	.error        (error)
);

ines_header u_header (
	.clk              (clk),
	.reset_nes        (reset_nes),
	.restart          (restart),
	.hdr_wr           (hdr_wr),
	.data             (data),
	.invert_mirroring (invert_mirroring),
	.hdr_done         (hdr_done),
	.hdr_ok           (hdr_ok),
	.prg_pages        (prg_pages),
	.chr_pages        (chr_pages),
	.mapper_flags     (mapper_flags)
);

cheat_code_assembler u_cheat (
	.clk          (clk),
	.reset_nes    (reset_nes),
	.cheat_active (cheat_active),
	.cheat_wr     (cheat_wr),
	.data         (data),
	.cheat_code   (cheat_code),
	.cheat_valid  (cheat_valid)
);

endmodule

/* testbench/nes_loader_chk.sv */
// Loader output rules
// Concurrent assertions bound into the loader top level
`timescale 1ns/100ps

module nes_loader_chk
	import nes_cart_pkg::*;
(
	input logic    clk,
	input logic    reset_nes,
	input mem_wr_t mem_wr,
	input logic    busy,
	input logic    done,
	input logic    error,
	input logic    cheat_valid
);

wr_while_busy: assert property (@(posedge clk) disable iff (reset_nes) mem_wr.wr |-> busy)
	else $error("Memory write strobe while not busy");

done_not_busy: assert property (@(posedge clk) disable iff (reset_nes) !(done && busy))
	else $error("Done and busy high together");

error_is_done: assert property (@(posedge clk) disable iff (reset_nes) error |-> done)
	else $error("Error without done");

// One cycle pulse per code
valid_pulse: assert property (@(posedge clk) disable iff (reset_nes)
	cheat_valid |=> !cheat_valid)
	else $error("Cheat valid longer than one cycle");

endmodule

bind nes_loader nes_loader_chk u_chk (
	.clk         (clk),
	.reset_nes   (reset_nes),
	.mem_wr      (mem_wr),
	.busy        (busy),
	.done        (done),
	.error       (error),
	.cheat_valid (cheat_valid)
);

/* testbench/tb_nes_loader.sv */
// Testbench for the cartridge and cheat loader
// Directed tests for good and rejected images, dirty headers, cheats and restart
`timescale 1ns/100ps

module tb_nes_loader
	import nes_cart_pkg::*, nes_cheat_pkg::*;
();

localparam logic [7:0] rom_filetype = 8'h00;
localparam int max_cycles = 80000;	// Tests take about 74000 cycles

logic          clk;
logic          reset_nes;
logic          download;
logic [7:0]    filetype;
logic [7:0]    data;
logic          data_wr;
logic          invert_mirroring;
mem_wr_t       mem_wr;
mapper_flags_t mapper_flags;
logic          busy;
logic          done;
logic          error;
cheat_code_t   cheat_code;
logic          cheat_valid;

logic [31:0] rng;
logic [7:0]  hdr_img [16];
logic [7:0]  cheat_stream [32];
int          codes_seen;
int          value_errs;
int          other_errs;
int          cycles;

nes_loader u_dut (.*);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

//////////////////////////////////////////////////////////////////////
// Compare tasks and stimulus helpers
//////////////////////////////////////////////////////////////////////

task automatic check_bit(input logic got, input logic exp, input string msg);
	if (got !== exp) begin
		$display("Fail at %0t: %s, got %b expected %b", $time, msg, got, exp);
		value_errs++;
	end
endtask

task automatic check_write(input mem_wr_t got, input mem_wr_t exp, input string msg);
	if (got !== exp) begin
		$display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
		value_errs++;
	end
endtask

task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp, input string msg);
	if (got !== exp) begin
		$display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
		value_errs++;
	end
endtask

task automatic check_code(input cheat_code_t got, input cheat_code_t exp, input string msg);
	if (got !== exp) begin
		$display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
		value_errs++;
	end
endtask

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [7:0] next_byte();
	rng = xorshift(rng);
	return rng[7:0];
endfunction

// Code layout: flags, address, compare, replace, each LSB first
function automatic cheat_code_t expected_code(input int n);
	cheat_code_t c;
	logic [7:0] b;
	c = '0;
	for (int j = 0; j < 16; j++) begin
		b = cheat_stream[16 * n + j];
		case (j / 4)
			0: c.flags[8 * (j % 4) +: 8] = b;
			1: c.addr[8 * (j % 4) +: 8] = b;
			2: c.compare[8 * (j % 4) +: 8] = b;
			default: c.replace[8 * (j % 4) +: 8] = b;
		endcase
	end
	return c;
endfunction

task automatic send_byte(input logic [7:0] b, output mem_wr_t w);
	@(negedge clk);
	data    = b;
	data_wr = 1'b1;
	#1;
	w = mem_wr;	// Combinational write, settled mid low phase
endtask

task automatic begin_download(input logic [7:0] ft);
	@(negedge clk);
	download = 1'b0;
	data_wr  = 1'b0;
	@(negedge clk);
	download = 1'b1;
	filetype = ft;
endtask

task automatic end_download();
	@(negedge clk);
	download = 1'b0;
	data_wr  = 1'b0;
endtask

task automatic build_header(input logic [7:0] prg, chr, f6, f7);
	hdr_img = '{8'h4E, 8'h45, 8'h53, 8'h1A, prg, chr, f6, f7,
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
endtask

task automatic send_header();
	mem_wr_t w;
	for (int i = 0; i < 16; i++) begin
		send_byte(hdr_img[i], w);
		check_bit(w.wr, 1'b0, "write strobe during header");
	end
endtask

task automatic send_data(input int count, input mem_addr_t base, input string what);
	mem_wr_t w;
	mem_wr_t exp;
	for (int i = 0; i < count; i++) begin
		exp.wr   = 1'b1;
		exp.addr = base + mem_addr_t'(i);
		exp.data = next_byte();
		send_byte(exp.data, w);
		check_write(w, exp, what);
	end
endtask

task automatic send_surplus(input int count);
	mem_wr_t w;
	for (int i = 0; i < count; i++) begin
		send_byte(next_byte(), w);
		check_bit(w.wr, 1'b0, "write strobe for a surplus byte");
	end
endtask

// Wait for busy (want_busy high) or for done, bounded
task automatic wait_status(input logic want_busy, input string what);
	int n;
	n = 0;
	while (!(want_busy ? busy : done) && n < 16) begin
		@(negedge clk);
		data_wr = 1'b0;
		#1;
		n++;
	end
	if (!(want_busy ? busy : done)) begin
		$display("%s did not happen by %0t", what, $time);
		other_errs++;
	end
endtask

task automatic load_rom(input int prg_n, input int chr_n, input mapper_flags_t exp);
	begin_download(rom_filetype);
	send_header();
	wait_status(1'b1, "Busy rising after a good header");
	send_data(prg_n << prg_page_shift, '0, "PRG write");
	send_data(chr_n << chr_page_shift, chr_base_addr, "CHR write");
	send_surplus(4);
	wait_status(1'b0, "Done after the last data byte");
	check_bit(error, 1'b0, "error after a good load");
	check_bit(busy, 1'b0, "busy after a good load");
	check_flags(mapper_flags, exp, "mapper flags");
	end_download();
endtask

task automatic expect_reject(input string what);
	begin_download(rom_filetype);
	send_header();
	wait_status(1'b0, what);
	check_bit(error, 1'b1, "error for a rejected header");
	check_bit(busy, 1'b0, "busy for a rejected header");
	send_surplus(4);
	end_download();
endtask

task automatic note_cheat_valid();
	if (cheat_valid) begin
		if (codes_seen < 2)
			check_code(cheat_code, expected_code(codes_seen), "cheat code");
		codes_seen++;
	end
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic valid_image_load();
	mapper_flags_t exp;
	exp          = '0;
	exp.mapper   = 8'd4;
	exp.prg_size = 3'd1;	// 2 pages
	build_header(8'd2, 8'd1, 8'h40, 8'h00);
	load_rom(2, 1, exp);
endtask

task automatic bad_signature_reject();
	build_header(8'd2, 8'd1, 8'h40, 8'h00);
	hdr_img[2] = 8'h00;
	expect_reject("Done for a bad signature");
endtask

task automatic trainer_image_reject();
	build_header(8'd2, 8'd1, 8'h44, 8'h00);	// Trainer bit set
	expect_reject("Done for an image with trainer");
endtask

task automatic dirty_header_chr_ram();
	mapper_flags_t exp;
	exp             = '0;
	exp.mapper      = 8'h02;	// High nibble dropped
	exp.has_chr_ram = 1'b1;
	build_header(8'd1, 8'd0, 8'h21, 8'h30);
	hdr_img[12]      = 8'h55;
	invert_mirroring = 1'b1;
	load_rom(1, 0, exp);
	invert_mirroring = 1'b0;
endtask

task automatic cheat_code_pair();
	mem_wr_t w;
	codes_seen = 0;
	begin_download(cheat_filetype);
	for (int k = 0; k < 32; k++) begin
		cheat_stream[k] = next_byte();
		send_byte(cheat_stream[k], w);
		check_bit(busy, 1'b0, "busy during cheat download");
		note_cheat_valid();
	end
	@(negedge clk);
	data_wr = 1'b0;
	#1;
	note_cheat_valid();
	if (codes_seen != 2) begin
		$display("Expected 2 cheat valid pulses but saw %0d", codes_seen);
		other_errs++;
	end
	end_download();
endtask

task automatic restart_mid_load();
	mapper_flags_t exp;
	build_header(8'd2, 8'd1, 8'h40, 8'h00);
	begin_download(rom_filetype);
	send_header();
	wait_status(1'b1, "Busy rising before restart");
	send_data(50, '0, "PRG write before restart");
	exp             = '0;
	exp.mapper      = 8'h02;
	exp.has_saves   = 1'b1;
	exp.has_chr_ram = 1'b1;
	build_header(8'd1, 8'd0, 8'h22, 8'h00);
	load_rom(1, 0, exp);	// Drops and raises download mid-load
endtask

initial begin
	reset_nes        = 1'b1;
	download         = 1'b0;
	filetype         = 8'h00;
	data             = 8'h00;
	data_wr          = 1'b0;
	invert_mirroring = 1'b0;
	rng              = 32'd1706;
	value_errs       = 0;
	other_errs       = 0;
	repeat (8) @(posedge clk);
	@(negedge clk);
	reset_nes = 1'b0;
	#1;
	check_bit(busy, 1'b0, "busy after reset");
	check_bit(done, 1'b0, "done after reset");
	check_bit(error, 1'b0, "error after reset");
	check_bit(mem_wr.wr, 1'b0, "write strobe after reset");
	check_bit(cheat_valid, 1'b0, "cheat_valid after reset");
	valid_image_load();
	bad_signature_reject();
	trainer_image_reject();
	dirty_header_chr_ram();
	cheat_code_pair();
	restart_mid_load();
	$display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
	if (value_errs == 0 && other_errs == 0)
		$display("No errors");
	else
		$display("Errors found");
	$finish;
end

// Run limit
initial begin
	cycles = 0;
	while (cycles < max_cycles) begin
		@(posedge clk);
		cycles++;
	end
	$display("Timeout, the tests did not finish within %0d cycles", max_cycles);
	$display("Errors found");
	$finish;
end

endmodule

/* nes_loader.f */
common/nes_cart_pkg.sv
common/nes_cheat_pkg.sv
loader/ines_header.sv
loader/rom_load_fsm.sv
logic/cheat_code_assembler.sv
logic/nes_loader.sv
testbench/nes_loader_chk.sv
testbench/tb_nes_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the nes_loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module tb_nes_loader -f nes_loader.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/Vtb_nes_loader > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$log"; then
	echo "Simulation FAILED"
	exit 1
fi

echo "Simulation PASSED"
exit 0
